/* include/hist_consts.svh */
`ifndef HIST_CONSTS_SVH
`define HIST_CONSTS_SVH

// events per pixel before the pixel index moves on
`define HIST_DATA_NUM 4

// pixels per acquisition
`define HIST_PIXEL_NUM 2

// acquisitions per frame
`define HIST_ACQ_NUM 2

// bin number width, 8 bins
`define HIST_BIN_W 3

// bin count width, saturates at 3
`define HIST_COUNT_W 2

// derived counter widths
`define HIST_DATA_W ($clog2(`HIST_DATA_NUM))
`define HIST_PIXEL_W ($clog2(`HIST_PIXEL_NUM))
`define HIST_ACQ_W ($clog2(`HIST_ACQ_NUM))

// bank address is {acq, pixel, bin}
`define HIST_ADDR_W (`HIST_ACQ_W + `HIST_PIXEL_W + `HIST_BIN_W)

// words per bank
`define HIST_DEPTH (`HIST_ACQ_NUM * `HIST_PIXEL_NUM * (1 << `HIST_BIN_W))

`endif

/* logic/hist_pkg.sv */
`include "hist_consts.svh"

package hist_pkg;

    // quantised arrival time of one event
    typedef logic [`HIST_BIN_W-1:0] bin_t;

    // per-bin event count
    typedef logic [`HIST_COUNT_W-1:0] count_t;

    // word address in one bank, acq index on top, bin at the bottom
    typedef logic [`HIST_ADDR_W-1:0] bank_addr_t;

    // event index inside one pixel
    typedef logic [`HIST_DATA_W-1:0] data_idx_t;

    // pixel index inside one acquisition
    typedef logic [`HIST_PIXEL_W-1:0] pixel_idx_t;

    // acquisition index inside one frame
    typedef logic [`HIST_ACQ_W-1:0] acq_idx_t;

    // control states
    // st_clear   sweep zeros into the active bank
    // st_collect count incoming events
    // st_swap    one cycle gap before the bank flips
    typedef enum logic [1:0] {
        st_clear,
        st_collect,
        st_swap
    } ctrl_state_t;

endpackage

/* logic/hist_ctrl.sv */
`timescale 1ns/1ps
`include "hist_consts.svh"

module hist_ctrl (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 wr_en,
    input  hist_pkg::bin_t       bin,
    output logic                 acc_en,
    output hist_pkg::bank_addr_t acc_addr,
    output logic                 clr_en,
    output hist_pkg::bank_addr_t clr_addr,
    output logic                 his_num,
    output logic                 busy,
    output logic                 frame_done
);
    import hist_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    data_idx_t   data_cnt;
    pixel_idx_t  pixel_idx;
    acq_idx_t    acq_idx;
    logic        data_last;
    logic        pixel_last;
    logic        acq_last;
    logic        frame_last;
    logic        clr_last;

    // wrap points of the three nested counters
    assign data_last  = (data_cnt == data_idx_t'(`HIST_DATA_NUM - 1));
    assign pixel_last = (pixel_idx == pixel_idx_t'(`HIST_PIXEL_NUM - 1));
    assign acq_last   = (acq_idx == acq_idx_t'(`HIST_ACQ_NUM - 1));

    // last event of the frame
    assign frame_last = acc_en && data_last && pixel_last && acq_last;

    // end of the clear sweep
    assign clr_last = (clr_addr == bank_addr_t'(`HIST_DEPTH - 1));

    // events only taken while collecting, dropped silently otherwise
    assign acc_en   = wr_en && (state == st_collect);
    assign acc_addr = {acq_idx, pixel_idx, bin};

    assign clr_en = (state == st_clear);
    assign busy   = (state != st_collect);

    always_comb begin
        state_nxt = state;
        case (state)
            st_clear: begin
                if (clr_last) begin
                    state_nxt = st_collect;
                end
            end
            st_collect: begin
                if (frame_last) begin
                    state_nxt = st_swap;
                end
            end
            st_swap: begin
                // new bank is cleared right after the flip
                state_nxt = st_clear;
            end
            default: begin
                state_nxt = st_clear;
            end
        endcase
    end

    // reset starts with a clear of bank 0
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= st_clear;
        end else begin
            state <= state_nxt;
        end
    end

    // clear sweep address
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clr_addr <= '0;
        end else if (clr_en) begin
            clr_addr <= clr_last ? '0 : clr_addr + 1'b1;
        end
    end

    // event -> pixel -> acquisition nesting
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            data_cnt  <= '0;
            pixel_idx <= '0;
            acq_idx   <= '0;
        end else if (acc_en) begin
            if (data_last) begin
                data_cnt <= '0;
                if (pixel_last) begin
                    pixel_idx <= '0;
                    if (acq_last) begin
                        acq_idx <= '0;
                    end else begin
                        acq_idx <= acq_idx + 1'b1;
                    end
                end else begin
                    pixel_idx <= pixel_idx + 1'b1;
                end
            end else begin
                data_cnt <= data_cnt + 1'b1;
            end
        end
    end

    // bank flip and frame-done pulse, both leave the swap state together
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            his_num    <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= (state == st_swap);
            if (state == st_swap) begin
                his_num <= ~his_num;
            end
        end
    end

endmodule

/* logic/hist_accum.sv */
`timescale 1ns/1ps

module hist_accum (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 acc_en,
    input  hist_pkg::bank_addr_t acc_addr,
    output logic                 ram_rd_en,
    output hist_pkg::bank_addr_t ram_rd_addr,
    input  hist_pkg::count_t     ram_rd_data,
    output logic                 ram_wr_en,
    output hist_pkg::bank_addr_t ram_wr_addr,
    output hist_pkg::count_t     ram_wr_data
);
    import hist_pkg::*;

    logic       s1_vld;
    bank_addr_t s1_addr;
    logic       prev_vld;
    bank_addr_t prev_addr;
    count_t     prev_data;
    count_t     base;
    count_t     next_cnt;

    // increment that sticks at all ones
    function automatic count_t sat_inc(input count_t cnt);
        count_t res_cnt;
        res_cnt = (cnt == '1) ? cnt : count_t'(cnt + 1'b1);
        return res_cnt;
    endfunction

    // stage 1, issue the read straight from the event
    assign ram_rd_en   = acc_en;
    assign ram_rd_addr = acc_addr;

    // stage 2 source
    // newest pending write first, then the write that landed with our read
    always_comb begin
        if (ram_wr_en && (ram_wr_addr == s1_addr)) begin
            base = ram_wr_data;
        end else if (prev_vld && (prev_addr == s1_addr)) begin
            base = prev_data;
        end else begin
            base = ram_rd_data;
        end
    end

    assign next_cnt = sat_inc(base);

    // valid flags of the pipe
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_vld    <= 1'b0;
            ram_wr_en <= 1'b0;
            prev_vld  <= 1'b0;
        end else begin
            s1_vld    <= acc_en;
            ram_wr_en <= s1_vld;
            prev_vld  <= ram_wr_en;
        end
    end

    // payload, qualified by the flags above
    always_ff @(posedge clk) begin
        s1_addr     <= acc_addr;
        ram_wr_addr <= s1_addr;
        ram_wr_data <= next_cnt;
        // copy of the write committed this edge
        prev_addr   <= ram_wr_addr;
        prev_data   <= ram_wr_data;
    end

endmodule

/* logic/hist_bank_ram.sv */
`timescale 1ns/1ps
`include "hist_consts.svh"

module hist_bank_ram (
    input  logic                 clk,
    input  logic                 his_num,
    input  logic                 rd_en,
    input  logic                 wr_en,
    input  logic                 clr_en,
    input  hist_pkg::bank_addr_t rd_addr,
    input  hist_pkg::bank_addr_t wr_addr,
    input  hist_pkg::bank_addr_t clr_addr,
    input  hist_pkg::count_t     wr_data,
    output hist_pkg::count_t     rd_data,
    input  logic                 ro_en,
    input  hist_pkg::bank_addr_t ro_addr,
    output hist_pkg::count_t     ro_data
);
    import hist_pkg::*;

    // two banks, ping-pong
    count_t mem [2][`HIST_DEPTH];

    // bank of the accumulation write
    // trails his_num by a cycle so the last write of a frame
    // still lands in the bank that is being frozen
    logic wr_bank;

    always_ff @(posedge clk) begin
        wr_bank <= his_num;
    end

    // clear wins over accumulation inside one bank
    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (clr_en && (his_num == 1'(b))) begin
                mem[b][clr_addr] <= '0;
            end else if (wr_en && (wr_bank == 1'(b))) begin
                mem[b][wr_addr] <= wr_data;
            end
        end
    end

    // accumulation read from the active bank
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[his_num][rd_addr];
        end
    end

    // readout from the frozen bank
    always_ff @(posedge clk) begin
        if (ro_en) begin
            ro_data <= mem[~his_num][ro_addr];
        end
    end

endmodule

/* logic/hist_readout.sv */
`timescale 1ns/1ps
`include "hist_consts.svh"

module hist_readout (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 rd_start,
    output logic                 ro_en,
    output hist_pkg::bank_addr_t ro_addr,
    input  hist_pkg::count_t     ro_data,
    output logic                 rd_busy,
    output logic                 rd_valid,
    output hist_pkg::bank_addr_t rd_addr,
    output hist_pkg::count_t     rd_data
);
    import hist_pkg::*;

    logic sweep_last;

    assign sweep_last = (ro_addr == bank_addr_t'(`HIST_DEPTH - 1));

    // sweep runs while ro_en is high, one address per cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            ro_en   <= 1'b0;
            ro_addr <= '0;
        end else if (ro_en) begin
            ro_addr <= sweep_last ? '0 : ro_addr + 1'b1;
            if (sweep_last) begin
                ro_en <= 1'b0;
            end
        end else if (rd_start && !rd_busy) begin
            // start only when fully idle
            ro_en   <= 1'b1;
            ro_addr <= '0;
        end
    end

    // one cycle behind the address, in step with the read data
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= ro_en;
        end
    end

    always_ff @(posedge clk) begin
        rd_addr <= ro_addr;
    end

    // busy until the last word has gone out
    assign rd_busy = ro_en || rd_valid;

    // synchronous read data is already aligned with rd_valid
    assign rd_data = ro_data;

endmodule

/* logic/hist_builder.sv */
`timescale 1ns/1ps

module hist_builder (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 wr_en,
    input  hist_pkg::bin_t       bin,
    input  logic                 rd_start,
    output logic                 busy,
    output logic                 his_num,
    output logic                 frame_done,
    output logic                 rd_busy,
    output logic                 rd_valid,
    output hist_pkg::bank_addr_t rd_addr,
    output hist_pkg::count_t     rd_data
);
    import hist_pkg::*;

    // event path, ctrl to accumulator
    logic       acc_en;
    bank_addr_t acc_addr;

    // clear sweep
    logic       clr_en;
    bank_addr_t clr_addr;

    // accumulator to active bank
    logic       ram_rd_en;
    bank_addr_t ram_rd_addr;
    count_t     ram_rd_data;
    logic       ram_wr_en;
    bank_addr_t ram_wr_addr;
    count_t     ram_wr_data;

    // readout to frozen bank
    logic       ro_en;
    bank_addr_t ro_addr;
    count_t     ro_data;

    hist_ctrl u_ctrl (
        .clk        (clk),
        .res        (res),
        .wr_en      (wr_en),
        .bin        (bin),
        .acc_en     (acc_en),
        .acc_addr   (acc_addr),
        .clr_en     (clr_en),
        .clr_addr   (clr_addr),
        .his_num    (his_num),
        .busy       (busy),
        .frame_done (frame_done)
    );

    hist_accum u_accum (
        .clk         (clk),
        .res         (res),
        .acc_en      (acc_en),
        .acc_addr    (acc_addr),
        .ram_rd_en   (ram_rd_en),
        .ram_rd_addr (ram_rd_addr),
        .ram_rd_data (ram_rd_data),
        .ram_wr_en   (ram_wr_en),
        .ram_wr_addr (ram_wr_addr),
        .ram_wr_data (ram_wr_data)
    );

    hist_bank_ram u_bank_ram (
        .clk      (clk),
        .his_num  (his_num),
        .rd_en    (ram_rd_en),
        .wr_en    (ram_wr_en),
        .clr_en   (clr_en),
        .rd_addr  (ram_rd_addr),
        .wr_addr  (ram_wr_addr),
        .clr_addr (clr_addr),
        .wr_data  (ram_wr_data),
        .rd_data  (ram_rd_data),
        .ro_en    (ro_en),
        .ro_addr  (ro_addr),
        .ro_data  (ro_data)
    );

    hist_readout u_readout (
        .clk      (clk),
        .res      (res),
        .rd_start (rd_start),
        .ro_en    (ro_en),
        .ro_addr  (ro_addr),
        .ro_data  (ro_data),
        .rd_busy  (rd_busy),
        .rd_valid (rd_valid),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

endmodule

/* verif/hist_properties.sv */
`timescale 1ns/1ps

module hist_properties (
    input logic                 clk,
    input logic                 res,
    input logic                 busy,
    input logic                 frame_done,
    input logic                 rd_valid,
    input hist_pkg::bank_addr_t rd_addr,
    input logic                 acc_en,
    input logic                 ram_wr_en
);
    import hist_pkg::*;

    // frame done is a single-cycle pulse
    frame_done_pulse: assert property (@(posedge clk) disable iff (!res)
        frame_done |=> !frame_done)
        else $error("frame_done high on two consecutive cycles");

    // readout words come out in address order without gaps
    rd_addr_step: assert property (@(posedge clk) disable iff (!res)
        (rd_valid ##1 rd_valid) |-> (rd_addr == bank_addr_t'($past(rd_addr) + 1'b1)))
        else $error("rd_addr did not step by one between valid words");

    // each bank write traces back to an event taken two cycles earlier outside busy
    no_event_when_busy: assert property (@(posedge clk) disable iff (!res)
        ram_wr_en |-> ($past(acc_en, 2) && !$past(busy, 2)))
        else $error("accumulation write from an event taken while busy");

endmodule

bind hist_builder hist_properties u_props (
    .clk        (clk),
    .res        (res),
    .busy       (busy),
    .frame_done (frame_done),
    .rd_valid   (rd_valid),
    .rd_addr    (rd_addr),
    .acc_en     (acc_en),
    .ram_wr_en  (ram_wr_en)
);

/* verif/hist_checker.sv */
`timescale 1ns/1ps
`include "hist_consts.svh"

module hist_checker (
    input  logic                                 clk,
    input  logic                                 res,
    input  logic                                 busy,
    input  logic                                 his_num,
    input  logic                                 frame_done,
    input  logic                                 rd_busy,
    input  logic                                 rd_valid,
    input  hist_pkg::bank_addr_t                 rd_addr,
    input  hist_pkg::count_t                     rd_data,
    input  logic [`HIST_DEPTH*`HIST_COUNT_W-1:0] exp_words,
    output int                                   err_cnt,
    output int                                   word_cnt
);
    import hist_pkg::*;

    logic   exp_his;
    logic   after_reset;
    int     busy_run;
    int     sweep_words;
    count_t exp_data;

    task automatic report(input string sig, input int exp_val, input int act_val);
        err_cnt++;
        $display("[ERROR] %0t %s: expected %0d, got %0d", $time, sig, exp_val, act_val);
    endtask

    initial begin
        err_cnt  = 0;
        word_cnt = 0;
    end

    // samples are the values held before each rising edge
    always @(posedge clk) begin
        if (!res) begin
            after_reset = 1'b1;
            exp_his     = 1'b0;
            busy_run    = 0;
            sweep_words = 0;
        end else begin
            // idle outputs on the first cycle out of reset
            if (after_reset) begin
                if (frame_done !== 1'b0) report("frame_done", 0, frame_done);
                if (rd_valid !== 1'b0) report("rd_valid", 0, rd_valid);
                if (rd_busy !== 1'b0) report("rd_busy", 0, rd_busy);
                after_reset = 1'b0;
            end
            // bank flips together with each frame done
            if (frame_done) exp_his = ~exp_his;
            if (his_num !== exp_his) report("his_num", exp_his, his_num);
            // clear length, restarted at frame done so the swap cycle is left out
            if (frame_done) begin
                busy_run = 1;
            end else if (busy) begin
                busy_run++;
            end else if (busy_run != 0) begin
                if (busy_run != `HIST_DEPTH) report("busy cycles", `HIST_DEPTH, busy_run);
                busy_run = 0;
            end
            // readout words against the model, in address order
            if (rd_valid) begin
                exp_data = exp_words[sweep_words*`HIST_COUNT_W +: `HIST_COUNT_W];
                if (rd_addr !== bank_addr_t'(sweep_words)) report("rd_addr", sweep_words, rd_addr);
                if (rd_data !== exp_data) report("rd_data", exp_data, rd_data);
                sweep_words++;
                word_cnt++;
            end else if (sweep_words != 0) begin
                // one full bank per sweep, a restart would add words
                if (sweep_words != `HIST_DEPTH) report("valid words", `HIST_DEPTH, sweep_words);
                sweep_words = 0;
            end
        end
    end

endmodule

/* verif/hist_builder_tb.sv */
`timescale 1ns/1ps
`include "hist_consts.svh"

module hist_builder_tb;
    import hist_pkg::*;

    localparam int EV_NUM    = `HIST_DATA_NUM * `HIST_PIXEL_NUM * `HIST_ACQ_NUM;
    localparam int FRAME_NUM = 4;
    localparam int TIMEOUT   = 200;
    localparam int CNT_MAX   = (1 << `HIST_COUNT_W) - 1;
    // wait conditions
    localparam int WAIT_IDLE = 0;
    localparam int WAIT_DONE = 1;
    localparam int WAIT_RD   = 2;

    logic       clk;
    logic       res;
    logic       wr_en;
    bin_t       bin;
    logic       rd_start;
    logic       busy;
    logic       his_num;
    logic       frame_done;
    logic       rd_busy;
    logic       rd_valid;
    bank_addr_t rd_addr;
    count_t     rd_data;
    int         err_cnt;
    int         word_cnt;
    int         timeouts;
    int         seed;
    // expected bank, word i at bits [i*W +: W]
    logic [`HIST_DEPTH*`HIST_COUNT_W-1:0] exp_words;
    // one row per frame, bins in arrival order
    bin_t frame_tbl [FRAME_NUM][EV_NUM];

    hist_builder DUT (
        .clk        (clk),
        .res        (res),
        .wr_en      (wr_en),
        .bin        (bin),
        .rd_start   (rd_start),
        .busy       (busy),
        .his_num    (his_num),
        .frame_done (frame_done),
        .rd_busy    (rd_busy),
        .rd_valid   (rd_valid),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    hist_checker u_checker (
        .clk        (clk),
        .res        (res),
        .busy       (busy),
        .his_num    (his_num),
        .frame_done (frame_done),
        .rd_busy    (rd_busy),
        .rd_valid   (rd_valid),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .exp_words  (exp_words),
        .err_cnt    (err_cnt),
        .word_cnt   (word_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reference histogram of one row, saturating counts
    task automatic build_model(input int f);
        int cnt [`HIST_DEPTH];
        int pix;
        int acq;
        int addr;
        for (int i = 0; i < `HIST_DEPTH; i++) begin
            cnt[i] = 0;
        end
        for (int i = 0; i < EV_NUM; i++) begin
            // events of a pixel first, then pixels, then acquisitions
            pix  = (i / `HIST_DATA_NUM) % `HIST_PIXEL_NUM;
            acq  = i / (`HIST_DATA_NUM * `HIST_PIXEL_NUM);
            addr = (acq << (`HIST_PIXEL_W + `HIST_BIN_W)) | (pix << `HIST_BIN_W);
            addr = addr | frame_tbl[f][i];
            if (cnt[addr] < CNT_MAX) cnt[addr]++;
        end
        for (int i = 0; i < `HIST_DEPTH; i++) begin
            exp_words[i*`HIST_COUNT_W +: `HIST_COUNT_W] = count_t'(cnt[i]);
        end
    endtask

    // edge by edge until the condition holds or the limit runs out
    task automatic wait_for(input int sel, input string what);
        int   cnt;
        logic hit;
        cnt = 0;
        hit = 1'b0;
        while (!hit && cnt < TIMEOUT) begin
            @(posedge clk);
            cnt++;
            case (sel)
                WAIT_IDLE: hit = !busy;
                WAIT_DONE: hit = frame_done;
                default:   hit = !rd_busy;
            endcase
        end
        if (!hit) begin
            timeouts++;
            $display("timeout at %0t while waiting for %s", $time, what);
        end
    endtask

    // back to back events, one per cycle
    task automatic drive_frame(input int f);
        for (int i = 0; i < EV_NUM; i++) begin
            wr_en <= 1'b1;
            bin   <= frame_tbl[f][i];
            @(posedge clk);
        end
        wr_en <= 1'b0;
    endtask

    task automatic start_readout();
        // junk events during the clear of the new bank, must be dropped
        rd_start <= 1'b1;
        for (int i = 0; i < 4; i++) begin
            wr_en <= 1'b1;
            bin   <= bin_t'(i);
            @(posedge clk);
            rd_start <= 1'b0;
        end
        wr_en    <= 1'b0;
        // second strobe inside the sweep, no restart expected
        rd_start <= 1'b1;
        @(posedge clk);
        rd_start <= 1'b0;
    endtask

    task automatic run_frame(input int f);
        build_model(f);
        wait_for(WAIT_IDLE, "busy to fall");
        if (timeouts != 0) return;
        drive_frame(f);
        wait_for(WAIT_DONE, "frame_done");
        if (timeouts != 0) return;
        start_readout();
        wait_for(WAIT_RD, "rd_busy to fall");
    endtask

    initial begin
        res       = 1'b0;
        wr_en     = 1'b0;
        bin       = '0;
        rd_start  = 1'b0;
        timeouts  = 0;
        exp_words = '0;
        seed      = 9247;
        // distinct bins, all-same bins (saturation), pairs, random
        frame_tbl = '{
            '{0, 1, 2, 3, 4, 5, 6, 7, 1, 3, 5, 7, 0, 2, 4, 6},
            '{5, 5, 5, 5, 2, 2, 2, 2, 7, 7, 7, 7, 0, 0, 0, 0},
            '{1, 1, 4, 6, 3, 0, 3, 2, 6, 2, 6, 7, 5, 5, 1, 0},
            '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}
        };
        for (int i = 0; i < EV_NUM; i++) begin
            frame_tbl[3][i] = bin_t'($random(seed));
        end
        repeat (2) @(posedge clk);
        res <= 1'b1;
        for (int f = 0; f < FRAME_NUM && timeouts == 0; f++) begin
            run_frame(f);
        end
        // let the checker take its last samples
        repeat (2) @(posedge clk);
        if (word_cnt != FRAME_NUM * `HIST_DEPTH) begin
            $display("readout delivered %0d words instead of %0d", word_cnt,
                     FRAME_NUM * `HIST_DEPTH);
        end
        $display("words checked: %0d, errors: %0d, timeouts: %0d", word_cnt, err_cnt, timeouts);
        if (err_cnt == 0 && timeouts == 0 && word_cnt == FRAME_NUM * `HIST_DEPTH) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+include
logic/hist_pkg.sv
logic/hist_ctrl.sv
logic/hist_accum.sv
logic/hist_bank_ram.sv
logic/hist_readout.sv
logic/hist_builder.sv
verif/hist_properties.sv
verif/hist_checker.sv
verif/hist_builder_tb.sv

/* Bender.yml */
package:
  name: hist_builder

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/hist_pkg.sv
      - logic/hist_ctrl.sv
      - logic/hist_accum.sv
      - logic/hist_bank_ram.sv
      - logic/hist_readout.sv
      - logic/hist_builder.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/hist_properties.sv
      - verif/hist_checker.sv
      - verif/hist_builder_tb.sv
